/* verilog/lsu_pkg.sv */
package lsu_pkg;

	localparam int WORD_W     = 32;
	localparam int ADDR_W     = 32;
	localparam int STRB_W     = WORD_W / 8;
	localparam int AXI_SIZE_W = 3;
	localparam int MEM_DEPTH  = 256; // 1 KiB of words
	localparam int MEM_IDX_W  = $clog2(MEM_DEPTH);

	// Memory map
	localparam logic [ADDR_W-1:0] RAM_BASE    = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] RAM_LIMIT   = 32'h0000_03FF;
	localparam logic [ADDR_W-1:0] ALIAS_BASE  = 32'h0000_8000;
	localparam logic [ADDR_W-1:0] ALIAS_LIMIT = 32'h0000_83FF;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'd0, // Same code as AXI size
		SIZE_HALF = 2'd1,
		SIZE_WORD = 2'd2
	} access_size_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	typedef enum logic [1:0] {
		REGION_RAM   = 2'd0,
		REGION_ALIAS = 2'd1,
		REGION_NONE  = 2'd2
	} region_e;

endpackage

/* verilog/lsu_addr_decode.sv */
`timescale 1ns/1ps

module lsu_addr_decode import lsu_pkg::*; (
	input  logic [ADDR_W-1:0] addr_i,
	input  access_size_e      size_i,
	output region_e           region_o,
	output logic [ADDR_W-1:0] offset_o,
	output logic              misaligned_o
);

	always_comb begin
		if (addr_i inside {[RAM_BASE:RAM_LIMIT]}) begin
			region_o = REGION_RAM;
			offset_o = addr_i - RAM_BASE;
		end else if (addr_i inside {[ALIAS_BASE:ALIAS_LIMIT]}) begin
			region_o = REGION_ALIAS;
			offset_o = addr_i - ALIAS_BASE; // Folded onto the RAM
		end else begin
			region_o = REGION_NONE;
			offset_o = '0;
		end
	end

	always_comb begin
		case (size_i)
			SIZE_HALF: begin
				misaligned_o = addr_i[0];
			end
			SIZE_WORD: begin
				misaligned_o = |addr_i[1:0];
			end
			default: begin
				misaligned_o = 1'b0; // Bytes never fault
			end
		endcase
	end

endmodule

/* verilog/lsu_store_align.sv */
`timescale 1ns/1ps

module lsu_store_align import lsu_pkg::*; (
	input  logic [1:0]            addr_lo_i,
	input  access_size_e          size_i,
	input  logic [WORD_W-1:0]     data_i,
	output logic [WORD_W-1:0]     wdata_o,
	output logic [STRB_W-1:0]     wstrb_o,
	output logic [AXI_SIZE_W-1:0] awsize_o
);

	assign awsize_o = {{(AXI_SIZE_W-2){1'b0}}, size_i};

	// Data is copied to every lane, the strobes pick the live one
	always_comb begin
		case (size_i)
			SIZE_BYTE: begin
				wdata_o = {STRB_W{data_i[7:0]}};
				wstrb_o = STRB_W'(1) << addr_lo_i;
			end
			SIZE_HALF: begin
				wdata_o = {(STRB_W/2){data_i[15:0]}};
				wstrb_o = STRB_W'(3) << {addr_lo_i[1], 1'b0};
			end
			default: begin
				wdata_o = data_i;
				wstrb_o = '1;
			end
		endcase
	end

endmodule

/* verilog/lsu_load_align.sv */
`timescale 1ns/1ps

module lsu_load_align import lsu_pkg::*; (
	input  logic [WORD_W-1:0] rdata_i,
	input  logic [1:0]        addr_lo_i,
	input  access_size_e      size_i,
	input  logic              unsigned_i,
	output logic [WORD_W-1:0] data_o
);

	logic [7:0]  byte_sel;
	logic [15:0] half_sel;
	logic        byte_ext;
	logic        half_ext;

	assign byte_sel = rdata_i[{addr_lo_i, 3'b000} +: 8];
	assign half_sel = rdata_i[{addr_lo_i[1], 4'b0000} +: 16];

	assign byte_ext = byte_sel[7] & ~unsigned_i; // Fill bit
	assign half_ext = half_sel[15] & ~unsigned_i;

	always_comb begin
		case (size_i)
			SIZE_BYTE: begin
				data_o = {{(WORD_W-8){byte_ext}}, byte_sel};
			end
			SIZE_HALF: begin
				data_o = {{(WORD_W-16){half_ext}}, half_sel};
			end
			default: begin
				data_o = rdata_i;
			end
		endcase
	end

endmodule

/* verilog/lsu_ctrl.sv */
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
	input  logic                  Axi_full,
	input  logic                  reset_i,

	input  logic                  req_valid_i,
	input  logic                  req_write_i,
	input  logic [ADDR_W-1:0]     req_addr_i,
	input  access_size_e          req_size_i,
	input  logic                  req_unsigned_i,
	input  logic [WORD_W-1:0]     req_wdata_i,

	input  region_e               region_i,
	input  logic                  misaligned_i,

	input  logic                  awready_i,
	input  logic                  wready_i,
	input  logic                  bvalid_i,
	input  axi_resp_e             bresp_i,
	input  logic                  arready_i,
	input  logic                  rvalid_i,
	input  axi_resp_e             rresp_i,
	input  logic [WORD_W-1:0]     load_data_i,

	output logic [ADDR_W-1:0]     held_addr_o,
	output access_size_e          held_size_o,
	output logic                  held_unsigned_o,
	output logic [WORD_W-1:0]     held_wdata_o,

	output logic                  awvalid_o,
	output logic                  wvalid_o,
	output logic                  bready_o,
	output logic                  arvalid_o,
	output logic [AXI_SIZE_W-1:0] arsize_o,
	output logic                  rready_o,

	output logic                  busy_o,
	output logic                  done_o,
	output axi_resp_e             resp_o,
	output logic [WORD_W-1:0]     rdata_o
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_DECIDE,
		S_AW,
		S_W,
		S_B,
		S_AR,
		S_R
	} state_e;

	state_e state;
	logic   held_write;
	logic   accept;
	logic   fault;
	logic   fault_end;
	logic   b_fire;
	logic   r_fire;

	assign accept    = (state == S_IDLE) && req_valid_i;
	assign fault     = (region_i == REGION_NONE) || misaligned_i;
	assign fault_end = (state == S_DECIDE) && fault;
	assign b_fire    = bready_o && bvalid_i;
	assign r_fire    = rready_o && rvalid_i;

	// Valids follow the state, so they hold while the slave stalls
	assign awvalid_o = (state == S_AW);
	assign wvalid_o  = (state == S_W);
	assign bready_o  = (state == S_B);
	assign arvalid_o = (state == S_AR);
	assign rready_o  = (state == S_R);
	assign arsize_o  = {{(AXI_SIZE_W-2){1'b0}}, held_size_o};
	assign busy_o    = (state != S_IDLE);

	always_ff @(posedge Axi_full) begin
		if (reset_i) begin
			state  <= S_IDLE;
			done_o <= 1'b0;
		end else begin
			done_o <= fault_end || b_fire || r_fire;
			case (state)
				S_IDLE: begin
					if (req_valid_i) state <= S_DECIDE;
				end
				S_DECIDE: begin
					if (fault) state <= S_IDLE;
					else if (held_write) state <= S_AW;
					else state <= S_AR;
				end
				S_AW: begin
					if (awready_i) state <= S_W;
				end
				S_W: begin
					if (wready_i) state <= S_B;
				end
				S_B: begin
					if (bvalid_i) state <= S_IDLE;
				end
				S_AR: begin
					if (arready_i) state <= S_R;
				end
				S_R: begin
					if (rvalid_i) state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge Axi_full) begin
		if (accept) begin
			held_write      <= req_write_i;
			held_addr_o     <= req_addr_i;
			held_size_o     <= req_size_i;
			held_unsigned_o <= req_unsigned_i;
			held_wdata_o    <= req_wdata_i;
		end
	end

	always_ff @(posedge Axi_full) begin
		if (fault_end) begin
			resp_o  <= (region_i == REGION_NONE) ? RESP_DECERR : RESP_SLVERR;
			rdata_o <= '0;
		end else if (b_fire) begin
			resp_o  <= bresp_i;
			rdata_o <= '0; // Stores return no data
		end else if (r_fire) begin
			resp_o  <= rresp_i;
			rdata_o <= load_data_i;
		end
	end

endmodule

/* verilog/axi_sram_slave.sv */
`timescale 1ns/1ps

module axi_sram_slave import lsu_pkg::*; (
	input  logic                  Axi_full,
	input  logic                  reset_i,
	input  logic                  stall_i,

	input  logic [ADDR_W-1:0]     awaddr_i,
	input  logic [AXI_SIZE_W-1:0] awsize_i,
	input  logic                  awvalid_i,
	output logic                  awready_o,

	input  logic [WORD_W-1:0]     wdata_i,
	input  logic [STRB_W-1:0]     wstrb_i,
	input  logic                  wvalid_i,
	output logic                  wready_o,

	output logic                  bvalid_o,
	output axi_resp_e             bresp_o,
	input  logic                  bready_i,

	input  logic [ADDR_W-1:0]     araddr_i,
	input  logic [AXI_SIZE_W-1:0] arsize_i,
	input  logic                  arvalid_i,
	output logic                  arready_o,

	output logic                  rvalid_o,
	output logic [WORD_W-1:0]     rdata_o,
	output axi_resp_e             rresp_o,
	input  logic                  rready_i
);

	logic [WORD_W-1:0]    mem [MEM_DEPTH];
	logic [MEM_IDX_W-1:0] aw_idx_q;
	axi_resp_e            aw_resp_q;
	logic                 bvalid_q;
	logic                 rvalid_q;
	axi_resp_e            ar_resp;
	axi_resp_e            aw_resp;

	assign awready_o = ~stall_i;
	assign wready_o  = ~stall_i;
	assign arready_o = ~stall_i;
	assign bvalid_o  = bvalid_q & ~stall_i; // Wait state hides the response
	assign rvalid_o  = rvalid_q & ~stall_i;

	// Beyond the array is DECERR, a size wider than the bus SLVERR
	assign aw_resp = (awaddr_i >= ADDR_W'(MEM_DEPTH * STRB_W)) ? RESP_DECERR :
		(awsize_i > AXI_SIZE_W'(SIZE_WORD)) ? RESP_SLVERR : RESP_OKAY;
	assign ar_resp = (araddr_i >= ADDR_W'(MEM_DEPTH * STRB_W)) ? RESP_DECERR :
		(arsize_i > AXI_SIZE_W'(SIZE_WORD)) ? RESP_SLVERR : RESP_OKAY;

	always_ff @(posedge Axi_full) begin
		if (awvalid_i && awready_o) begin
			aw_idx_q  <= awaddr_i[MEM_IDX_W+1:2];
			aw_resp_q <= aw_resp;
		end
		if (wvalid_i && wready_o) bresp_o <= aw_resp_q;
		if (arvalid_i && arready_o) begin
			rdata_o <= mem[araddr_i[MEM_IDX_W+1:2]];
			rresp_o <= ar_resp;
		end
	end

	always_ff @(posedge Axi_full) begin
		if (reset_i) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wvalid_i && wready_o) bvalid_q <= 1'b1;
			else if (bvalid_o && bready_i) bvalid_q <= 1'b0;
			if (arvalid_i && arready_o) rvalid_q <= 1'b1;
			else if (rvalid_o && rready_i) rvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge Axi_full) begin
		if (reset_i) begin
			for (int i = 0; i < MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (wvalid_i && wready_o && aw_resp_q == RESP_OKAY) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (wstrb_i[b]) mem[aw_idx_q][b*8 +: 8] <= wdata_i[b*8 +: 8];
			end
		end
	end

endmodule

/* verilog/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
	input  logic              Axi_full,
	input  logic              reset_i,
	input  logic              mem_stall_i,

	input  logic              req_valid_i,
	input  logic              req_write_i,
	input  logic [ADDR_W-1:0] req_addr_i,
	input  access_size_e      req_size_i,
	input  logic              req_unsigned_i,
	input  logic [WORD_W-1:0] req_wdata_i,

	output logic              busy_o,
	output logic              done_o,
	output axi_resp_e         resp_o,
	output logic [WORD_W-1:0] rdata_o
);

	logic [ADDR_W-1:0]     held_addr;
	access_size_e          held_size;
	logic                  held_unsigned;
	logic [WORD_W-1:0]     held_wdata;

	region_e               region;
	logic [ADDR_W-1:0]     offset; // Drives both AWADDR and ARADDR
	logic                  misaligned;
	logic [WORD_W-1:0]     load_data;

	logic                  awvalid;
	logic                  awready;
	logic [AXI_SIZE_W-1:0] awsize;
	logic [WORD_W-1:0]     wdata;
	logic [STRB_W-1:0]     wstrb;
	logic                  wvalid;
	logic                  wready;
	logic                  bvalid;
	logic                  bready;
	axi_resp_e             bresp;
	logic                  arvalid;
	logic                  arready;
	logic [AXI_SIZE_W-1:0] arsize;
	logic                  rvalid;
	logic                  rready;
	logic [WORD_W-1:0]     rdata;
	axi_resp_e             rresp;

	lsu_ctrl u_ctrl (
		.Axi_full(Axi_full), .reset_i(reset_i),
		.req_valid_i(req_valid_i), .req_write_i(req_write_i), .req_addr_i(req_addr_i),
		.req_size_i(req_size_i), .req_unsigned_i(req_unsigned_i), .req_wdata_i(req_wdata_i),
		.region_i(region), .misaligned_i(misaligned),
		.awready_i(awready), .wready_i(wready), .bvalid_i(bvalid), .bresp_i(bresp),
		.arready_i(arready), .rvalid_i(rvalid), .rresp_i(rresp), .load_data_i(load_data),
		.held_addr_o(held_addr), .held_size_o(held_size),
		.held_unsigned_o(held_unsigned), .held_wdata_o(held_wdata),
		.awvalid_o(awvalid), .wvalid_o(wvalid), .bready_o(bready),
		.arvalid_o(arvalid), .arsize_o(arsize), .rready_o(rready),
		.busy_o(busy_o), .done_o(done_o), .resp_o(resp_o), .rdata_o(rdata_o)
	);

	lsu_addr_decode u_decode (
		.addr_i(held_addr), .size_i(held_size),
		.region_o(region), .offset_o(offset), .misaligned_o(misaligned)
	);

	lsu_store_align u_store (
		.addr_lo_i(held_addr[1:0]), .size_i(held_size), .data_i(held_wdata),
		.wdata_o(wdata), .wstrb_o(wstrb), .awsize_o(awsize)
	);

	lsu_load_align u_load (
		.rdata_i(rdata), .addr_lo_i(held_addr[1:0]), .size_i(held_size),
		.unsigned_i(held_unsigned), .data_o(load_data)
	);

	axi_sram_slave u_sram (
		.Axi_full(Axi_full), .reset_i(reset_i), .stall_i(mem_stall_i),
		.awaddr_i(offset), .awsize_i(awsize), .awvalid_i(awvalid), .awready_o(awready),
		.wdata_i(wdata), .wstrb_i(wstrb), .wvalid_i(wvalid), .wready_o(wready),
		.bvalid_o(bvalid), .bresp_o(bresp), .bready_i(bready),
		.araddr_i(offset), .arsize_i(arsize), .arvalid_i(arvalid), .arready_o(arready),
		.rvalid_o(rvalid), .rdata_o(rdata), .rresp_o(rresp), .rready_i(rready)
	);

endmodule

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #50 clk_o = ~clk_o; // 100 ns period
	end

	initial begin
		reset_o = 1'b1;
		repeat (4) @(posedge clk_o);
		#1;
		reset_o = 1'b0; // Released off the edge like all stimulus
	end

endmodule

/* tb/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb import lsu_pkg::*; ();

	logic              clk;
	logic              reset;
	logic              mem_stall;
	logic              req_valid = 1'b0;
	logic              req_write = 1'b0;
	logic [ADDR_W-1:0] req_addr = '0;
	access_size_e      req_size = SIZE_WORD;
	logic              req_unsigned = 1'b0;
	logic [WORD_W-1:0] req_wdata = '0;
	logic              busy;
	logic              done;
	axi_resp_e         resp;
	logic [WORD_W-1:0] rdata;

	string             t_name[$]; // Stimulus table, one index per entry
	logic              t_write[$];
	logic [ADDR_W-1:0] t_addr[$];
	access_size_e      t_size[$];
	logic              t_unsigned[$];
	logic [WORD_W-1:0] t_wdata[$];
	axi_resp_e         t_resp[$];
	logic [WORD_W-1:0] t_rdata[$];
	integer            seed = 32'hcde8;
	logic [31:0]       rnd;
	logic              stall_en = 1'b0;
	int                n_entries = 0;

	tb_clock_gen u_clock (.clk_o(clk), .reset_o(reset));

	lsu_top UUT (
		.Axi_full(clk), .reset_i(reset), .mem_stall_i(mem_stall),
		.req_valid_i(req_valid), .req_write_i(req_write), .req_addr_i(req_addr),
		.req_size_i(req_size), .req_unsigned_i(req_unsigned), .req_wdata_i(req_wdata),
		.busy_o(busy), .done_o(done), .resp_o(resp), .rdata_o(rdata)
	);

	task automatic add_entry(input string name, input logic wr, input logic [ADDR_W-1:0] addr,
		input access_size_e size, input logic uns, input logic [WORD_W-1:0] wdata,
		input axi_resp_e exp_resp, input logic [WORD_W-1:0] exp_rdata);
		t_name.push_back(name);
		t_write.push_back(wr);
		t_addr.push_back(addr);
		t_size.push_back(size);
		t_unsigned.push_back(uns);
		t_wdata.push_back(wdata);
		t_resp.push_back(exp_resp);
		t_rdata.push_back(exp_rdata);
	endtask

	task automatic abort_run();
		$display("Regression failed");
		$fatal(1, "stopped at the first failing check");
	endtask

	task automatic check_resp(input string name, input axi_resp_e exp, input axi_resp_e act);
		if (act !== exp) begin
			$display("ERROR %s: expected %s, actual %s", name, exp.name(), act.name());
			abort_run();
		end
	endtask

	task automatic check_data(input string name, input logic [WORD_W-1:0] exp,
		input logic [WORD_W-1:0] act);
		if (act !== exp) begin
			$display("ERROR %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic apply_entry(input int i);
		req_valid    = 1'b1;
		req_write    = t_write[i];
		req_addr     = t_addr[i];
		req_size     = t_size[i];
		req_unsigned = t_unsigned[i];
		req_wdata    = t_wdata[i];
		@(posedge clk);
		#1;
		req_wdata = ~t_wdata[i]; // Strobe stays high into the busy cycle
		while (done !== 1'b1) begin
			if (busy !== 1'b1) begin
				$display("busy_o went low before done_o while running %s", t_name[i]);
				abort_run();
			end
			@(posedge clk);
			#1;
			req_valid = 1'b0;
		end
		check_resp(t_name[i], t_resp[i], resp);
		check_data(t_name[i], t_rdata[i], rdata);
	endtask

	initial begin
		add_entry("st_word", 1'b1, 32'h4, SIZE_WORD, 1'b0, 32'h1234_5678, RESP_OKAY, '0);
		add_entry("ld_word", 1'b0, 32'h4, SIZE_WORD, 1'b0, '0, RESP_OKAY, 32'h1234_5678);
		// Lane merge, then extension of the merged word
		add_entry("st_base", 1'b1, 32'h8, SIZE_WORD, 1'b0, 32'h1111_1111, RESP_OKAY, '0);
		add_entry("st_byte1", 1'b1, 32'h9, SIZE_BYTE, 1'b0, 32'h5566_77AB, RESP_OKAY, '0);
		add_entry("st_half1", 1'b1, 32'hA, SIZE_HALF, 1'b0, 32'h9988_CDEF, RESP_OKAY, '0);
		add_entry("ld_merged", 1'b0, 32'h8, SIZE_WORD, 1'b0, '0, RESP_OKAY, 32'hCDEF_AB11);
		add_entry("lb_lane1", 1'b0, 32'h9, SIZE_BYTE, 1'b0, '0, RESP_OKAY, 32'hFFFF_FFAB);
		add_entry("lbu_lane1", 1'b0, 32'h9, SIZE_BYTE, 1'b1, '0, RESP_OKAY, 32'h0000_00AB);
		add_entry("lh_hi", 1'b0, 32'hA, SIZE_HALF, 1'b0, '0, RESP_OKAY, 32'hFFFF_CDEF);
		add_entry("lhu_hi", 1'b0, 32'hA, SIZE_HALF, 1'b1, '0, RESP_OKAY, 32'h0000_CDEF);
		add_entry("st_alias", 1'b1, 32'h8010, SIZE_WORD, 1'b0, 32'hA5A5_0001, RESP_OKAY, '0);
		add_entry("st_ram", 1'b1, 32'h14, SIZE_WORD, 1'b0, 32'h5A5A_0002, RESP_OKAY, '0);
		add_entry("ld_alias", 1'b0, 32'h8014, SIZE_WORD, 1'b0, '0, RESP_OKAY, 32'h5A5A_0002);
		// Faulted accesses must not reach the memory
		add_entry("st_unmapped", 1'b1, 32'h8400, SIZE_WORD, 1'b0, 32'hFFFF_FFFF, RESP_DECERR, '0);
		add_entry("ld_unmapped", 1'b0, 32'h400, SIZE_WORD, 1'b0, '0, RESP_DECERR, '0);
		add_entry("st_misaligned", 1'b1, 32'h11, SIZE_HALF, 1'b0, 32'hFFFF_FFFF, RESP_SLVERR, '0);
		add_entry("ld_misaligned", 1'b0, 32'h16, SIZE_WORD, 1'b0, '0, RESP_SLVERR, '0);
		add_entry("ld_ram", 1'b0, 32'h10, SIZE_WORD, 1'b0, '0, RESP_OKAY, 32'hA5A5_0001);
		add_entry("ld_word0", 1'b0, 32'h0, SIZE_WORD, 1'b0, '0, RESP_OKAY, '0);
		// Scrub touched words so every replayed store has to land again
		add_entry("clr_word1", 1'b1, 32'h4, SIZE_WORD, 1'b0, '0, RESP_OKAY, '0);
		add_entry("clr_word2", 1'b1, 32'h8, SIZE_WORD, 1'b0, '0, RESP_OKAY, '0);
		add_entry("clr_word4", 1'b1, 32'h10, SIZE_WORD, 1'b0, '0, RESP_OKAY, '0);
		add_entry("clr_word5", 1'b1, 32'h14, SIZE_WORD, 1'b0, '0, RESP_OKAY, '0);
		n_entries = t_name.size();
		@(negedge reset);
		for (int pass = 0; pass < 2; pass++) begin
			stall_en = (pass == 1); // Second pass with wait states
			for (int i = 0; i < n_entries; i++) begin
				apply_entry(i);
			end
		end
		$display("Regression passed");
		$finish;
	end

	initial begin
		mem_stall = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			rnd       = $random(seed);
			mem_stall = stall_en & rnd[0];
		end
	end

	// Two passes of the table, 64 cycles of 100 ns per entry
	initial begin
		wait (n_entries > 0);
		#(n_entries * 2 * 64 * 100);
		$display("Timeout, done_o never arrived for the running request");
		abort_run();
	end

endmodule

/* flist.f */
verilog/lsu_pkg.sv
verilog/lsu_addr_decode.sv
verilog/lsu_store_align.sv
verilog/lsu_load_align.sv
verilog/lsu_ctrl.sv
verilog/axi_sram_slave.sv
verilog/lsu_top.sv
tb/tb_clock_gen.sv
tb/lsu_tb.sv

/* Makefile */
# Verilator build and run of the load/store unit regression
TOP := lsu_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "test   build with Verilator, run the regression, search $(LOG) for the result"
	@echo "clean  remove obj_dir and $(LOG)"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
